//--- src/rv32i_types_pkg.sv
// rv32i isa types
`default_nettype none

package rv32i_types_pkg;

    typedef logic [31:0] word_t;  // machine word, used for every pc and address

    // mcause exception codes, machine mode subset
    typedef enum logic [3:0] {
        CAUSE_INSN_FAULT  = 4'd1,   // instruction access fault
        CAUSE_ILLEGAL     = 4'd2,   // illegal instruction
        CAUSE_BREAKPOINT  = 4'd3,   // ebreak
        CAUSE_LOAD_FAULT  = 4'd5,   // load access fault
        CAUSE_STORE_FAULT = 4'd7,   // store/amo access fault
        CAUSE_ECALL       = 4'd11   // ecall from m-mode
    } cause_e;

    // machine external interrupt is code 11 as well
    // only mcause[31] tells it apart from ecall
    localparam cause_e CAUSE_EXT_INTR = CAUSE_ECALL;

endpackage

`default_nettype wire

//--- src/pipe_ctrl_pkg.sv
// pipeline and trap control definitions
`default_nettype none

package pipe_ctrl_pkg;

    // fetch address after reset
    localparam rv32i_types_pkg::word_t RESET_PC    = 32'h0000_0200;
    // direct mode mtvec, not writable here
    localparam rv32i_types_pkg::word_t TRAP_VECTOR = 32'h0000_0100;
    localparam rv32i_types_pkg::word_t PC_STEP     = 32'd4;  // no compressed insns

    // trap unit state
    typedef enum logic {
        TRAP_IDLE    = 1'b0,  // normal execution, interrupts open
        TRAP_HANDLER = 1'b1   // inside handler until ret
    } trap_state_e;

endpackage

`default_nettype wire

//--- src/stage3_hazard_unit.sv
// three stage hazard unit
`default_nettype none

module stage3_hazard_unit (
    // datapath status
    input  logic                   i_mem_busy,
    input  logic                   d_mem_busy,
    input  logic                   dren,         // load in memory stage
    input  logic                   dwen,         // store in memory stage
    input  logic                   ex_busy,      // multi-cycle op in execute
    input  logic                   fence_stall,
    input  logic                   halt,
    input  logic                   jump,
    input  logic                   branch,       // taken branch
    // fault sources
    input  logic                   fault_insn,
    input  logic                   illegal_insn,
    input  logic                   fault_l,
    input  logic                   fault_s,
    input  logic                   breakpoint,
    input  logic                   env,          // ecall
    input  logic                   ret,          // mret in execute
    input  logic                   intr,         // pending external interrupt
    input  logic                   intr_enable,  // from trap unit
    input  logic                   insert_pc,    // trap unit redirect
    // stage state
    input  logic                   valid_e,
    input  logic                   valid_m,
    input  rv32i_types_pkg::word_t pc_f,
    input  rv32i_types_pkg::word_t pc_e,
    input  rv32i_types_pkg::word_t pc_m,
    // pipeline controls
    output logic                   pc_en,
    output logic                   npc_sel,
    output logic                   if_ex_stall,
    output logic                   ex_mem_stall,
    output logic                   if_ex_flush,
    output logic                   ex_mem_flush,
    output logic                   suppress_iren,
    output logic                   suppress_data,
    output logic                   fetch_valid,
    // notifications to trap unit
    output logic                   exception,
    output logic                   intr_taken,
    output rv32i_types_pkg::word_t epc
);

    logic dmem_access;
    logic branch_jump;
    logic wait_for_imem;
    logic wait_for_dmem;
    logic ctrl_hazard;  // exception, taken interrupt or ret

    assign dmem_access   = dren || dwen;
    assign branch_jump   = branch || jump;
    assign wait_for_imem = i_mem_busy && !suppress_iren;
    assign wait_for_dmem = dmem_access && d_mem_busy && !suppress_data;

    assign npc_sel = branch_jump;

    // any fault is an exception, interrupts lose to exceptions
    assign exception = fault_insn | illegal_insn | fault_l | fault_s
                     | breakpoint | env;
    assign intr_taken  = intr && !exception && intr_enable;
    assign ctrl_hazard = exception || intr_taken || ret;

    // no fetch request while a redirect is pending
    assign suppress_iren = branch_jump || ctrl_hazard || insert_pc;
    assign suppress_data = exception;  // faulting access must not reach memory
    assign fetch_valid   = !wait_for_imem;

    // oldest valid insn takes the trap, interrupt lets the memory op retire
    assign epc = (valid_m && !intr_taken) ? pc_m :
                 (valid_e ? pc_e : pc_f);

    // memory stage slow or halted, everyone waits
    assign ex_mem_stall = wait_for_dmem
                       || fence_stall
                       || halt;

    assign if_ex_stall = ex_mem_stall               // later stage stuck
                      || fence_stall
                      || (ex_busy && !ctrl_hazard); // control hazard beats busy X

    assign if_ex_flush = ctrl_hazard
                      || branch_jump
                      || (wait_for_imem && !ex_mem_stall);  // bubble while fetch lags

    assign ex_mem_flush = ctrl_hazard
                       || branch_jump
                       || (if_ex_stall && !ex_mem_stall);   // bubble behind busy X

    // pc moves when fetch can hand off, or on any redirect
    assign pc_en = (!if_ex_stall && !wait_for_imem)
                || branch_jump
                || insert_pc
                || ret;

    always_comb begin
        // a halted pipe must not see redirects
        assert final (!halt || !((if_ex_stall && if_ex_flush)
                              || (ex_mem_stall && ex_mem_flush)))
            else $error("stall and flush together during halt");
    end

endmodule

`default_nettype wire

//--- src/pc_unit.sv
// fetch pc register
`default_nettype none

module pc_unit (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   pc_en,
    input  logic                   npc_sel,        // branch or jump taken
    input  logic                   insert_pc,      // trap or return redirect
    input  rv32i_types_pkg::word_t branch_target,
    input  rv32i_types_pkg::word_t priv_pc,
    output rv32i_types_pkg::word_t pc_f
);
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;

    word_t npc;

    // trap redirect wins over branch, branch over sequential
    always_comb begin
        if (insert_pc)
            npc = priv_pc;
        else if (npc_sel)
            npc = branch_target;
        else
            npc = pc_f + PC_STEP;
    end

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n)
            pc_f <= RESET_PC;
        else if (pc_en)
            pc_f <= npc;  // holds otherwise
    end

    // targets and vectors from outside must keep fetch aligned
    assert property (@(posedge CLK) disable iff (!rst_n)
        pc_en |=> (pc_f[1:0] == 2'b00))
        else $error("pc_f lost word alignment");

endmodule

`default_nettype wire

//--- src/pipe_stage_regs.sv
// fetch/execute and execute/memory latches
`default_nettype none

module pipe_stage_regs (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   if_ex_stall,
    input  logic                   ex_mem_stall,
    input  logic                   if_ex_flush,
    input  logic                   ex_mem_flush,
    input  logic                   fetch_valid,   // fetch has an insn this cycle
    input  rv32i_types_pkg::word_t pc_f,
    output logic                   valid_e,
    output logic                   valid_m,
    output rv32i_types_pkg::word_t pc_e,
    output rv32i_types_pkg::word_t pc_m
);

    // valid bits, flush beats stall
    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            valid_e <= 1'b0;
            valid_m <= 1'b0;
        end else begin
            if (if_ex_flush)
                valid_e <= 1'b0;         // bubble into execute
            else if (!if_ex_stall)
                valid_e <= fetch_valid;

            if (ex_mem_flush)
                valid_m <= 1'b0;         // bubble into memory
            else if (!ex_mem_stall)
                valid_m <= valid_e;
        end
    end

    // pc payload follows the valid bit, meaningless when invalid
    always_ff @(posedge CLK) begin
        if (!if_ex_stall)
            pc_e <= pc_f;
        if (!ex_mem_stall)
            pc_m <= pc_e;
    end

    // execute must not move on while memory holds, or its insn is lost
    assert property (@(posedge CLK) disable iff (!rst_n)
        ex_mem_stall |-> if_ex_stall)
        else $error("ex_mem_stall without if_ex_stall");

endmodule

`default_nettype wire

//--- src/priv_trap_unit.sv
// machine mode trap unit
`default_nettype none

module priv_trap_unit (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   exception,
    input  logic                   intr_taken,
    input  logic                   ret,
    input  logic                   fault_insn,
    input  logic                   illegal_insn,
    input  logic                   fault_l,
    input  logic                   fault_s,
    input  logic                   breakpoint,
    input  logic                   env,
    input  rv32i_types_pkg::word_t epc,
    output logic                   insert_pc,
    output logic                   intr_enable,
    output logic                   trap_active,
    output rv32i_types_pkg::word_t priv_pc,
    output rv32i_types_pkg::word_t mepc,
    output rv32i_types_pkg::word_t mcause
);
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;

    trap_state_e state;
    cause_e      cause;
    logic        trap_take;

    assign trap_take = exception || intr_taken;

    // cause priority, insn side first
    always_comb begin
        if (fault_insn)
            cause = CAUSE_INSN_FAULT;
        else if (illegal_insn)
            cause = CAUSE_ILLEGAL;
        else if (breakpoint)
            cause = CAUSE_BREAKPOINT;
        else if (env)
            cause = CAUSE_ECALL;
        else if (fault_l)
            cause = CAUSE_LOAD_FAULT;
        else if (fault_s)
            cause = CAUSE_STORE_FAULT;
        else
            cause = CAUSE_EXT_INTR;  // only reached on an interrupt
    end

    assign insert_pc   = trap_take || ret;
    assign priv_pc     = (ret && !trap_take) ? mepc : TRAP_VECTOR;  // trap wins
    assign intr_enable = (state == TRAP_IDLE);  // no nesting
    assign trap_active = (state == TRAP_HANDLER);

    always_ff @(posedge CLK or negedge rst_n) begin
        if (!rst_n) begin
            state  <= TRAP_IDLE;
            mepc   <= '0;
            mcause <= '0;
        end else if (trap_take) begin
            state  <= TRAP_HANDLER;
            mepc   <= epc;
            mcause <= {intr_taken, 27'd0, cause};  // bit 31 marks interrupt
        end else if (ret) begin
            state  <= TRAP_IDLE;
        end
    end

    // mret outside a handler has nowhere to return to
    assert property (@(posedge CLK) disable iff (!rst_n)
        ret |-> (state == TRAP_HANDLER))
        else $error("ret seen in TRAP_IDLE");

endmodule

`default_nettype wire

//--- src/stage3_pipe_ctrl.sv
// three stage pipeline control top
`default_nettype none

module stage3_pipe_ctrl (
    input  logic                   CLK,
    input  logic                   rst_n,
    input  logic                   i_mem_busy,
    input  logic                   d_mem_busy,
    input  logic                   dren,
    input  logic                   dwen,
    input  logic                   ex_busy,
    input  logic                   fence_stall,
    input  logic                   halt,
    input  logic                   jump,
    input  logic                   branch,
    input  logic                   fault_insn,
    input  logic                   illegal_insn,
    input  logic                   fault_l,
    input  logic                   fault_s,
    input  logic                   breakpoint,
    input  logic                   env,
    input  logic                   ret,
    input  logic                   intr,
    input  rv32i_types_pkg::word_t branch_target,
    output rv32i_types_pkg::word_t pc_f,
    output logic                   valid_e,
    output rv32i_types_pkg::word_t pc_e,
    output logic                   valid_m,
    output rv32i_types_pkg::word_t pc_m,
    output logic                   if_ex_stall,
    output logic                   ex_mem_stall,
    output logic                   if_ex_flush,
    output logic                   ex_mem_flush,
    output logic                   suppress_iren,
    output logic                   suppress_data,
    output logic                   trap_active,
    output rv32i_types_pkg::word_t mepc,
    output rv32i_types_pkg::word_t mcause
);
    import rv32i_types_pkg::*;

    logic  pc_en;
    logic  npc_sel;
    logic  fetch_valid;
    logic  exception;
    logic  intr_taken;
    logic  insert_pc;
    logic  intr_enable;
    word_t epc;
    word_t priv_pc;

    // all stall/flush decisions, zero latency
    stage3_hazard_unit hazard_i (
        .i_mem_busy   (i_mem_busy),
        .d_mem_busy   (d_mem_busy),
        .dren         (dren),
        .dwen         (dwen),
        .ex_busy      (ex_busy),
        .fence_stall  (fence_stall),
        .halt         (halt),
        .jump         (jump),
        .branch       (branch),
        .fault_insn   (fault_insn),
        .illegal_insn (illegal_insn),
        .fault_l      (fault_l),
        .fault_s      (fault_s),
        .breakpoint   (breakpoint),
        .env          (env),
        .ret          (ret),
        .intr         (intr),
        .intr_enable  (intr_enable),
        .insert_pc    (insert_pc),
        .valid_e      (valid_e),
        .valid_m      (valid_m),
        .pc_f         (pc_f),
        .pc_e         (pc_e),
        .pc_m         (pc_m),
        .pc_en        (pc_en),
        .npc_sel      (npc_sel),
        .if_ex_stall  (if_ex_stall),
        .ex_mem_stall (ex_mem_stall),
        .if_ex_flush  (if_ex_flush),
        .ex_mem_flush (ex_mem_flush),
        .suppress_iren(suppress_iren),
        .suppress_data(suppress_data),
        .fetch_valid  (fetch_valid),
        .exception    (exception),
        .intr_taken   (intr_taken),
        .epc          (epc)
    );

    pc_unit pc_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .pc_en        (pc_en),
        .npc_sel      (npc_sel),
        .insert_pc    (insert_pc),
        .branch_target(branch_target),
        .priv_pc      (priv_pc),
        .pc_f         (pc_f)
    );

    pipe_stage_regs regs_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .if_ex_stall  (if_ex_stall),
        .ex_mem_stall (ex_mem_stall),
        .if_ex_flush  (if_ex_flush),
        .ex_mem_flush (ex_mem_flush),
        .fetch_valid  (fetch_valid),
        .pc_f         (pc_f),
        .valid_e      (valid_e),
        .valid_m      (valid_m),
        .pc_e         (pc_e),
        .pc_m         (pc_m)
    );

    // mepc/mcause and redirect target
    priv_trap_unit trap_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .exception    (exception),
        .intr_taken   (intr_taken),
        .ret          (ret),
        .fault_insn   (fault_insn),
        .illegal_insn (illegal_insn),
        .fault_l      (fault_l),
        .fault_s      (fault_s),
        .breakpoint   (breakpoint),
        .env          (env),
        .epc          (epc),
        .insert_pc    (insert_pc),
        .intr_enable  (intr_enable),
        .trap_active  (trap_active),
        .priv_pc      (priv_pc),
        .mepc         (mepc),
        .mcause       (mcause)
    );

endmodule

`default_nettype wire

//--- verif/stage3_pipe_ctrl_tb.sv
// pipeline control testbench
`default_nettype none

module stage3_pipe_ctrl_tb;
    import rv32i_types_pkg::*;
    import pipe_ctrl_pkg::*;

    // bit positions in the stimulus vector
    localparam int IMEM_BUSY = 0;
    localparam int DMEM_BUSY = 1;
    localparam int DREN      = 2;
    localparam int DWEN      = 3;
    localparam int EX_BUSY   = 4;
    localparam int FENCE     = 5;
    localparam int HALT      = 6;
    localparam int JUMP      = 7;
    localparam int BRANCH    = 8;
    localparam int F_INSN    = 9;
    localparam int ILLEGAL   = 10;
    localparam int F_LOAD    = 11;
    localparam int F_STORE   = 12;
    localparam int BRKPT     = 13;
    localparam int ECALL     = 14;
    localparam int RET       = 15;
    localparam int INTR      = 16;

    // one row per clock cycle
    typedef struct packed {
        logic [31:0] stim;
        word_t       target;
        logic [5:0]  ctl;     // suppress_iren, if_ex/ex_mem stall, if_ex/ex_mem flush, suppress_data
        word_t       pc;      // pc_f after the next rising edge
        logic        ve;
        logic        vm;
        logic        ta;      // trap_active
        word_t       mepc;
        word_t       mcause;
    } row_t;

    row_t        rows [0:63];
    int          n_rows;
    int          n_errors;
    integer      seed;
    logic        table_ready;
    logic        cur_ta;          // trap fields carried into the next rows
    word_t       cur_mepc;
    word_t       cur_mcause;
    word_t       last_pc;
    word_t       exp_pc_e;        // latch model, pc held in execute
    word_t       exp_pc_m;
    word_t       pc_before;       // pc_f ahead of the coming edge

    logic        CLK;
    logic        rst_n;
    logic [31:0] drive_vec;
    word_t       branch_target;
    word_t       pc_f;
    word_t       pc_e;
    word_t       pc_m;
    word_t       mepc;
    word_t       mcause;
    logic        valid_e;
    logic        valid_m;
    logic        trap_active;
    logic        suppress_data;
    logic        suppress_iren;
    logic        if_ex_stall;
    logic        ex_mem_stall;
    logic        if_ex_flush;
    logic        ex_mem_flush;

    stage3_pipe_ctrl dut_i (
        .CLK          (CLK),
        .rst_n        (rst_n),
        .i_mem_busy   (drive_vec[IMEM_BUSY]),
        .d_mem_busy   (drive_vec[DMEM_BUSY]),
        .dren         (drive_vec[DREN]),
        .dwen         (drive_vec[DWEN]),
        .ex_busy      (drive_vec[EX_BUSY]),
        .fence_stall  (drive_vec[FENCE]),
        .halt         (drive_vec[HALT]),
        .jump         (drive_vec[JUMP]),
        .branch       (drive_vec[BRANCH]),
        .fault_insn   (drive_vec[F_INSN]),
        .illegal_insn (drive_vec[ILLEGAL]),
        .fault_l      (drive_vec[F_LOAD]),
        .fault_s      (drive_vec[F_STORE]),
        .breakpoint   (drive_vec[BRKPT]),
        .env          (drive_vec[ECALL]),
        .ret          (drive_vec[RET]),
        .intr         (drive_vec[INTR]),
        .branch_target(branch_target),
        .pc_f         (pc_f),
        .valid_e      (valid_e),
        .pc_e         (pc_e),
        .valid_m      (valid_m),
        .pc_m         (pc_m),
        .if_ex_stall  (if_ex_stall),
        .ex_mem_stall (ex_mem_stall),
        .if_ex_flush  (if_ex_flush),
        .ex_mem_flush (ex_mem_flush),
        .suppress_iren(suppress_iren),
        .suppress_data(suppress_data),
        .trap_active  (trap_active),
        .mepc         (mepc),
        .mcause       (mcause)
    );

    always #10 CLK = ~CLK;

    task automatic add_row(input logic [31:0] vec, input word_t target, input logic [5:0] ctl,
                           input word_t pc, input logic ve, input logic vm);
        rows[n_rows].stim   = vec;
        rows[n_rows].target = target;
        rows[n_rows].ctl    = ctl;
        rows[n_rows].pc     = pc;
        rows[n_rows].ve     = ve;
        rows[n_rows].vm     = vm;
        rows[n_rows].ta     = cur_ta;
        rows[n_rows].mepc   = cur_mepc;
        rows[n_rows].mcause = cur_mcause;
        last_pc = pc;
        n_rows++;
    endtask

    // row that changes the trap registers
    task automatic add_trap(input logic [31:0] vec, input logic [5:0] ctl, input word_t pc,
                            input logic ve, input logic vm, input logic ta,
                            input word_t epc_exp, input word_t cause_exp);
        cur_ta     = ta;
        cur_mepc   = epc_exp;
        cur_mcause = cause_exp;
        add_row(vec, 32'd0, ctl, pc, ve, vm);
    endtask

    // no status raised, random target must be ignored
    task automatic add_idle(input logic ve, input logic vm);
        word_t target;
        target = $random(seed) & 32'hFFFF_FFFC;  // keep it word aligned
        add_row(32'd0, target, 6'b000000, last_pc + PC_STEP, ve, vm);
    endtask

    task automatic build_table();
        cur_ta     = 1'b0;
        cur_mepc   = 32'd0;
        cur_mcause = 32'd0;
        last_pc    = RESET_PC;
        add_idle(1'b1, 1'b0);                                             // pipe fills
        add_idle(1'b1, 1'b1);
        add_idle(1'b1, 1'b1);
        add_row((1 << DREN) | (1 << DMEM_BUSY), 32'd0, 6'b011000, 32'h20C, 1'b1, 1'b1);
        add_row(1 << HALT, 32'd0, 6'b011000, 32'h20C, 1'b1, 1'b1);       // everything frozen
        add_row(1 << IMEM_BUSY, 32'd0, 6'b000100, 32'h20C, 1'b0, 1'b1);  // fetch bubble
        add_row(1 << EX_BUSY, 32'd0, 6'b010010, 32'h20C, 1'b0, 1'b0);    // bubble into mem
        add_idle(1'b1, 1'b0);
        add_idle(1'b1, 1'b1);
        add_row(1 << BRANCH, 32'h400, 6'b100110, 32'h400, 1'b0, 1'b0);
        add_idle(1'b1, 1'b0);
        add_row(1 << JUMP, 32'h800, 6'b100110, 32'h800, 1'b0, 1'b0);
        add_idle(1'b1, 1'b0);
        add_idle(1'b1, 1'b1);
        // single faults, epc from memory stage then from fetch inside the handler
        add_trap(1 << ILLEGAL, 6'b100111, 32'h100, 1'b0, 1'b0, 1'b1, 32'h800, 32'd2);
        add_trap(1 << BRKPT, 6'b100111, 32'h100, 1'b0, 1'b0, 1'b1, 32'h100, 32'd3);
        add_trap(1 << ECALL, 6'b100111, 32'h100, 1'b0, 1'b0, 1'b1, 32'h100, 32'd11);
        add_trap(1 << F_LOAD, 6'b100111, 32'h100, 1'b0, 1'b0, 1'b1, 32'h100, 32'd5);
        add_trap(1 << RET, 6'b100110, 32'h100, 1'b0, 1'b0, 1'b0, 32'h100, 32'd5);
        add_idle(1'b1, 1'b0);
        add_idle(1'b1, 1'b1);
        add_idle(1'b1, 1'b1);
        add_trap(1 << F_STORE, 6'b100111, 32'h100, 1'b0, 1'b0, 1'b1, 32'h104, 32'd7);
        add_trap(1 << RET, 6'b100110, 32'h104, 1'b0, 1'b0, 1'b0, 32'h104, 32'd7);
        add_row(1 << BRANCH, 32'hA00, 6'b100110, 32'hA00, 1'b0, 1'b0);
        add_trap(1 << F_INSN, 6'b100111, 32'h100, 1'b0, 1'b0, 1'b1, 32'hA00, 32'd1); // from pc_f
        add_trap(1 << RET, 6'b100110, 32'hA00, 1'b0, 1'b0, 1'b0, 32'hA00, 32'd1);
        add_row(1 << JUMP, 32'hC00, 6'b100110, 32'hC00, 1'b0, 1'b0);
        add_idle(1'b1, 1'b0);
        // several faults at once, breakpoint beats ecall and access faults
        add_trap((1 << BRKPT) | (1 << ECALL) | (1 << F_LOAD) | (1 << F_STORE), 6'b100111,
                 32'h100, 1'b0, 1'b0, 1'b1, 32'hC00, 32'd3);
        add_trap(1 << RET, 6'b100110, 32'hC00, 1'b0, 1'b0, 1'b0, 32'hC00, 32'd3);
        add_idle(1'b1, 1'b0);
        add_idle(1'b1, 1'b1);
        add_idle(1'b1, 1'b1);
        add_trap((1 << ECALL) | (1 << F_LOAD) | (1 << F_STORE), 6'b100111,
                 32'h100, 1'b0, 1'b0, 1'b1, 32'hC04, 32'd11);
        add_idle(1'b1, 1'b0);
        add_row(1 << INTR, 32'd0, 6'b000000, 32'h108, 1'b1, 1'b1);       // masked in handler
        add_trap(1 << RET, 6'b100110, 32'hC04, 1'b0, 1'b0, 1'b0, 32'hC04, 32'd11);
        add_idle(1'b1, 1'b0);
        add_idle(1'b1, 1'b1);
        // taken interrupt skips the memory stage for epc
        add_trap(1 << INTR, 6'b100110, 32'h100, 1'b0, 1'b0, 1'b1, 32'hC08, 32'h8000_000B);
        add_trap(1 << RET, 6'b100110, 32'hC08, 1'b0, 1'b0, 1'b0, 32'hC08, 32'h8000_000B);
        add_idle(1'b1, 1'b0);
        add_idle(1'b1, 1'b1);
    endtask

    task automatic report_mismatch(input int r, input string what, input word_t got,
                                   input word_t exp);
        n_errors++;
        $display("MISMATCH at %0t: row %0d %s got %h expected %h", $time, r, what, got, exp);
    endtask

    // combinational outputs, sampled mid cycle
    task automatic check_controls(input int r, input logic [5:0] ctl);
        logic [5:0] got;
        got = {suppress_iren, if_ex_stall, ex_mem_stall, if_ex_flush, ex_mem_flush,
               suppress_data};
        assert (got == ctl)
            else report_mismatch(r, "stall/flush/suppress", {26'd0, got}, {26'd0, ctl});
    endtask

    // registered outputs, sampled on the falling edge after the update
    task automatic check_state(input int r, input word_t pc, input logic ve, input logic vm,
                               input logic ta, input word_t epc_exp, input word_t cause_exp);
        assert (pc_f == pc) else report_mismatch(r, "pc_f", pc_f, pc);
        assert ({valid_e, valid_m} == {ve, vm})
            else report_mismatch(r, "valid_e/valid_m", {30'd0, valid_e, valid_m},
                                 {30'd0, ve, vm});
        assert (trap_active == ta)
            else report_mismatch(r, "trap_active", {31'd0, trap_active}, {31'd0, ta});
        assert (mepc == epc_exp) else report_mismatch(r, "mepc", mepc, epc_exp);
        assert (mcause == cause_exp) else report_mismatch(r, "mcause", mcause, cause_exp);
    endtask

    // stage pc only means something while its valid bit is set
    task automatic check_payload(input int r, input logic ve, input logic vm,
                                 input word_t pe_exp, input word_t pm_exp);
        if (ve)
            assert (pc_e == pe_exp) else report_mismatch(r, "pc_e", pc_e, pe_exp);
        if (vm)
            assert (pc_m == pm_exp) else report_mismatch(r, "pc_m", pc_m, pm_exp);
    endtask

    initial begin
        CLK           = 1'b0;
        rst_n         = 1'b0;
        drive_vec     = 32'd0;
        branch_target = 32'd0;
        table_ready   = 1'b0;
        n_rows        = 0;
        n_errors      = 0;
        seed          = 32'h1767_49ce;
        exp_pc_e      = 32'd0;
        exp_pc_m      = 32'd0;
        pc_before     = RESET_PC;
        build_table();
        table_ready = 1'b1;
        repeat (2) @(negedge CLK);
        rst_n = 1'b1;
        check_controls(-1, 6'b000000);
        check_state(-1, RESET_PC, 1'b0, 1'b0, 1'b0, 32'd0, 32'd0);
        for (int i = 0; i < n_rows; i++) begin
            drive_vec     = rows[i].stim;  // falling edge drive
            branch_target = rows[i].target;
            #1;
            check_controls(i, rows[i].ctl);
            // an unstalled latch takes the pc of the stage before it
            if (!rows[i].ctl[3])
                exp_pc_m = exp_pc_e;
            if (!rows[i].ctl[4])
                exp_pc_e = pc_before;
            pc_before = rows[i].pc;
            @(negedge CLK);
            check_state(i, rows[i].pc, rows[i].ve, rows[i].vm, rows[i].ta,
                        rows[i].mepc, rows[i].mcause);
            check_payload(i, rows[i].ve, rows[i].vm, exp_pc_e, exp_pc_m);
        end
        $display("rows applied: %0d, errors: %0d", n_rows, n_errors);
        if (n_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // run limit scales with the table length
    initial begin
        wait (table_ready);
        #(n_rows * 20 * 4);
        $display("timeout: the row loop did not finish within %0d time units", n_rows * 80);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- stage3_pipe_ctrl.f
src/rv32i_types_pkg.sv
src/pipe_ctrl_pkg.sv
src/stage3_hazard_unit.sv
src/pc_unit.sv
src/pipe_stage_regs.sv
src/priv_trap_unit.sv
src/stage3_pipe_ctrl.sv
verif/stage3_pipe_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the pipeline control testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module stage3_pipe_ctrl_tb \
    -f stage3_pipe_ctrl.f \
    -o stage3_pipe_ctrl_sim

out=$(./obj_dir/stage3_pipe_ctrl_sim || true)
echo "$out"

if echo "$out" | grep -qx "All checks passed"; then
    exit 0
else
    exit 1
fi
